//--- ooo_backend.f
rtl/backend_pkg.sv
rtl/execute_unit.sv
rtl/reorder_buffer.sv
rtl/rename_dispatch.sv
rtl/ooo_backend.sv
tests/backend_properties.sv
tests/tb_ooo_backend.sv

//--- rtl/backend_pkg.sv
`default_nettype none

package backend_pkg;

  // ====================
  // Widths
  // ====================
  localparam int unsigned XLEN       = 32;
  localparam int unsigned AREG_W     = 5;
  localparam int unsigned IMM_W      = 16;
  localparam int unsigned MUL_STAGES = 3;

  // ====================
  // Encodings
  // ====================
  typedef enum logic [2:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_ADDI,
    OP_MUL
  } alu_op_e;

  typedef enum logic [1:0] {
    ENTRY_FREE,
    ENTRY_PENDING,
    ENTRY_DONE
  } entry_state_e;

endpackage

`default_nettype wire

//--- rtl/execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

module execute_unit
  import backend_pkg::*;
#(
  parameter int unsigned ROB_DEPTH = 8,
  localparam int unsigned TAG_W = $clog2(ROB_DEPTH)
) (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               flush_i,
  input  logic               disp_valid_i,
  input  alu_op_e            disp_op_i,
  input  logic [TAG_W-1:0]   disp_tag_i,
  input  logic [XLEN-1:0]    disp_a_i,
  input  logic [XLEN-1:0]    disp_b_i,
  output logic               alu_wb_valid_o,
  output logic [TAG_W-1:0]   alu_wb_tag_o,
  output logic [XLEN-1:0]    alu_wb_data_o,
  output logic               mul_wb_valid_o,
  output logic [TAG_W-1:0]   mul_wb_tag_o,
  output logic [XLEN-1:0]    mul_wb_data_o
);

  localparam int unsigned HALF = XLEN / 2;

  logic                    alu_issue;
  logic                    mul_issue;
  logic [XLEN-1:0]         alu_result;

  logic [MUL_STAGES-1:0]   mul_valid_q;
  logic [TAG_W-1:0]        mul_tag_q  [MUL_STAGES];
  logic [XLEN-1:0]         mul_data_q [MUL_STAGES];
  logic [HALF-1:0]         mul_cross_q;

  assign alu_issue = disp_valid_i && (disp_op_i != OP_MUL);
  assign mul_issue = disp_valid_i && (disp_op_i == OP_MUL);

  // ====================
  // ALU
  // ====================
  always_comb begin
    case (disp_op_i)
      OP_ADD, OP_ADDI: alu_result = disp_a_i + disp_b_i;
      OP_SUB:          alu_result = disp_a_i - disp_b_i;
      OP_AND:          alu_result = disp_a_i & disp_b_i;
      OP_OR:           alu_result = disp_a_i | disp_b_i;
      OP_XOR:          alu_result = disp_a_i ^ disp_b_i;
      default:         alu_result = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      alu_wb_valid_o <= 1'b0;
      mul_valid_q    <= '0;
    end else if (flush_i) begin
      alu_wb_valid_o <= 1'b0;
      mul_valid_q    <= '0;
    end else begin
      alu_wb_valid_o <= alu_issue;
      mul_valid_q    <= {mul_valid_q[MUL_STAGES-2:0], mul_issue};
    end
  end

  // ====================
  // Multiplier
  // ====================
  always_ff @(posedge clk_i) begin
    if (alu_issue) begin
      alu_wb_tag_o  <= disp_tag_i;
      alu_wb_data_o <= alu_result;
    end
    // Stage 0 forms the low partial product and the cross term
    if (mul_issue) begin
      mul_tag_q[0]  <= disp_tag_i;
      mul_data_q[0] <= disp_a_i * XLEN'(disp_b_i[HALF-1:0]);
      mul_cross_q   <= disp_a_i[HALF-1:0] * disp_b_i[XLEN-1:HALF];
    end
    // Only the low half of the cross term reaches the 32-bit result
    mul_tag_q[1]  <= mul_tag_q[0];
    mul_data_q[1] <= mul_data_q[0] + {mul_cross_q, {HALF{1'b0}}};
    for (int s = 2; s < MUL_STAGES; s++) begin
      mul_tag_q[s]  <= mul_tag_q[s-1];
      mul_data_q[s] <= mul_data_q[s-1];
    end
  end

  assign mul_wb_valid_o = mul_valid_q[MUL_STAGES-1];
  assign mul_wb_tag_o   = mul_tag_q[MUL_STAGES-1];
  assign mul_wb_data_o  = mul_data_q[MUL_STAGES-1];

endmodule

`default_nettype wire

//--- rtl/ooo_backend.sv
`timescale 1ns/1ps
`default_nettype none

module ooo_backend
  import backend_pkg::*;
#(
  parameter int unsigned ROB_DEPTH = 8
) (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                flush_i,
  input  logic                uop_valid_i,
  output logic                uop_ready_o,
  input  alu_op_e             uop_op_i,
  input  logic [AREG_W-1:0]   uop_rd_i,
  input  logic [AREG_W-1:0]   uop_rs1_i,
  input  logic [AREG_W-1:0]   uop_rs2_i,
  input  logic [IMM_W-1:0]    uop_imm_i,
  output logic                commit_valid_o,
  output logic [AREG_W-1:0]   commit_rd_o,
  output logic [XLEN-1:0]     commit_wdata_o
);

  localparam int unsigned TAG_W = $clog2(ROB_DEPTH);

  // ====================
  // Rename and dispatch
  // ====================
  logic                    rob_ready;
  logic [TAG_W-1:0]        rob_tail;
  logic [1:0][TAG_W-1:0]   query_tag;
  logic [1:0]              query_done;
  logic [1:0][XLEN-1:0]    query_data;
  logic [TAG_W-1:0]        commit_tag;

  logic                    disp_valid;
  alu_op_e                 disp_op;
  logic [AREG_W-1:0]       disp_rd;
  logic [TAG_W-1:0]        disp_tag;
  logic [XLEN-1:0]         disp_a;
  logic [XLEN-1:0]         disp_b;

  rename_dispatch #(
    .ROB_DEPTH(ROB_DEPTH)
  ) u_rename_dispatch (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .flush_i       (flush_i),
    .uop_valid_i   (uop_valid_i),
    .uop_ready_o   (uop_ready_o),
    .uop_op_i      (uop_op_i),
    .uop_rd_i      (uop_rd_i),
    .uop_rs1_i     (uop_rs1_i),
    .uop_rs2_i     (uop_rs2_i),
    .uop_imm_i     (uop_imm_i),
    .rob_ready_i   (rob_ready),
    .rob_tail_i    (rob_tail),
    .query_tag_o   (query_tag),
    .query_done_i  (query_done),
    .query_data_i  (query_data),
    .commit_valid_i(commit_valid_o),
    .commit_tag_i  (commit_tag),
    .commit_rd_i   (commit_rd_o),
    .commit_wdata_i(commit_wdata_o),
    .disp_valid_o  (disp_valid),
    .disp_op_o     (disp_op),
    .disp_rd_o     (disp_rd),
    .disp_tag_o    (disp_tag),
    .disp_a_o      (disp_a),
    .disp_b_o      (disp_b)
  );

  // ====================
  // ROB
  // ====================
  logic                    alu_wb_valid;
  logic [TAG_W-1:0]        alu_wb_tag;
  logic [XLEN-1:0]         alu_wb_data;
  logic                    mul_wb_valid;
  logic [TAG_W-1:0]        mul_wb_tag;
  logic [XLEN-1:0]         mul_wb_data;

  reorder_buffer #(
    .ROB_DEPTH(ROB_DEPTH)
  ) u_reorder_buffer (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .flush_i       (flush_i),
    .alloc_valid_i (disp_valid),
    .alloc_rd_i    (disp_rd),
    .alloc_ready_o (rob_ready),
    .tail_o        (rob_tail),
    .query_tag_i   (query_tag),
    .query_done_o  (query_done),
    .query_data_o  (query_data),
    .alu_wb_valid_i(alu_wb_valid),
    .alu_wb_tag_i  (alu_wb_tag),
    .alu_wb_data_i (alu_wb_data),
    .mul_wb_valid_i(mul_wb_valid),
    .mul_wb_tag_i  (mul_wb_tag),
    .mul_wb_data_i (mul_wb_data),
    .commit_valid_o(commit_valid_o),
    .commit_tag_o  (commit_tag),
    .commit_rd_o   (commit_rd_o),
    .commit_wdata_o(commit_wdata_o)
  );

  // ====================
  // Execute
  // ====================
  execute_unit #(
    .ROB_DEPTH(ROB_DEPTH)
  ) u_execute_unit (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .flush_i       (flush_i),
    .disp_valid_i  (disp_valid),
    .disp_op_i     (disp_op),
    .disp_tag_i    (disp_tag),
    .disp_a_i      (disp_a),
    .disp_b_i      (disp_b),
    .alu_wb_valid_o(alu_wb_valid),
    .alu_wb_tag_o  (alu_wb_tag),
    .alu_wb_data_o (alu_wb_data),
    .mul_wb_valid_o(mul_wb_valid),
    .mul_wb_tag_o  (mul_wb_tag),
    .mul_wb_data_o (mul_wb_data)
  );

endmodule

`default_nettype wire

//--- rtl/rename_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module rename_dispatch
  import backend_pkg::*;
#(
  parameter int unsigned ROB_DEPTH = 8,
  localparam int unsigned TAG_W = $clog2(ROB_DEPTH)
) (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  logic                     flush_i,
  input  logic                     uop_valid_i,
  output logic                     uop_ready_o,
  input  alu_op_e                  uop_op_i,
  input  logic [AREG_W-1:0]        uop_rd_i,
  input  logic [AREG_W-1:0]        uop_rs1_i,
  input  logic [AREG_W-1:0]        uop_rs2_i,
  input  logic [IMM_W-1:0]         uop_imm_i,
  input  logic                     rob_ready_i,
  input  logic [TAG_W-1:0]         rob_tail_i,
  output logic [1:0][TAG_W-1:0]    query_tag_o,
  input  logic [1:0]               query_done_i,
  input  logic [1:0][XLEN-1:0]     query_data_i,
  input  logic                     commit_valid_i,
  input  logic [TAG_W-1:0]         commit_tag_i,
  input  logic [AREG_W-1:0]        commit_rd_i,
  input  logic [XLEN-1:0]          commit_wdata_i,
  output logic                     disp_valid_o,
  output alu_op_e                  disp_op_o,
  output logic [AREG_W-1:0]        disp_rd_o,
  output logic [TAG_W-1:0]         disp_tag_o,
  output logic [XLEN-1:0]          disp_a_o,
  output logic [XLEN-1:0]          disp_b_o
);

  localparam int unsigned NUM_AREGS = 2 ** AREG_W;

  logic [XLEN-1:0]          rf_q [NUM_AREGS];
  logic [NUM_AREGS-1:0]     map_valid_q;
  logic [TAG_W-1:0]         map_tag_q [NUM_AREGS];

  logic [1:0][AREG_W-1:0]   src_idx;
  logic [1:0]               src_used;
  logic [1:0]               src_mapped;
  logic [1:0]               src_pending;
  logic [1:0][XLEN-1:0]     src_val;
  logic [XLEN-1:0]          imm_ext;

  assign src_idx[0]  = uop_rs1_i;
  assign src_idx[1]  = uop_rs2_i;
  assign src_used[0] = 1'b1;
  assign src_used[1] = (uop_op_i != OP_ADDI);
  assign imm_ext     = {{(XLEN - IMM_W){uop_imm_i[IMM_W-1]}}, uop_imm_i};

  // ====================
  // Operand selection
  // ====================
  always_comb begin
    for (int k = 0; k < 2; k++) begin
      query_tag_o[k] = map_tag_q[src_idx[k]];
      // Producer retiring this cycle is read as if already in the register file
      src_mapped[k]  = map_valid_q[src_idx[k]] &&
                       !(commit_valid_i && (map_tag_q[src_idx[k]] == commit_tag_i));
      src_pending[k] = src_used[k] && src_mapped[k] && !query_done_i[k];
      if (src_mapped[k]) begin
        src_val[k] = query_data_i[k];
      end else if (src_idx[k] == '0) begin
        src_val[k] = '0;
      end else if (commit_valid_i && (commit_rd_i == src_idx[k])) begin
        src_val[k] = commit_wdata_i;
      end else begin
        src_val[k] = rf_q[src_idx[k]];
      end
    end
  end

  assign uop_ready_o  = rob_ready_i && !flush_i && !(|src_pending);
  assign disp_valid_o = uop_valid_i && uop_ready_o;
  assign disp_op_o    = uop_op_i;
  assign disp_rd_o    = uop_rd_i;
  assign disp_tag_o   = rob_tail_i;
  assign disp_a_o     = src_val[0];
  assign disp_b_o     = (uop_op_i == OP_ADDI) ? imm_ext : src_val[1];

  // ====================
  // Register file and map
  // ====================
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rf_q        <= '{default: '0};
      map_valid_q <= '0;
    end else begin
      if (commit_valid_i && (commit_rd_i != '0)) begin
        rf_q[commit_rd_i] <= commit_wdata_i;
      end
      if (flush_i) begin
        map_valid_q <= '0;
      end else begin
        if (commit_valid_i && (map_tag_q[commit_rd_i] == commit_tag_i)) begin
          map_valid_q[commit_rd_i] <= 1'b0;
        end
        // A new producer overrides the clear above
        if (disp_valid_o && (uop_rd_i != '0)) begin
          map_valid_q[uop_rd_i] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (disp_valid_o && (uop_rd_i != '0)) begin
      map_tag_q[uop_rd_i] <= rob_tail_i;
    end
  end

endmodule

`default_nettype wire

//--- rtl/reorder_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer
  import backend_pkg::*;
#(
  parameter int unsigned ROB_DEPTH = 8,
  localparam int unsigned TAG_W = $clog2(ROB_DEPTH),
  localparam int unsigned CNT_W = $clog2(ROB_DEPTH + 1)
) (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  logic                     flush_i,
  input  logic                     alloc_valid_i,
  input  logic [AREG_W-1:0]        alloc_rd_i,
  output logic                     alloc_ready_o,
  output logic [TAG_W-1:0]         tail_o,
  input  logic [1:0][TAG_W-1:0]    query_tag_i,
  output logic [1:0]               query_done_o,
  output logic [1:0][XLEN-1:0]     query_data_o,
  input  logic                     alu_wb_valid_i,
  input  logic [TAG_W-1:0]         alu_wb_tag_i,
  input  logic [XLEN-1:0]          alu_wb_data_i,
  input  logic                     mul_wb_valid_i,
  input  logic [TAG_W-1:0]         mul_wb_tag_i,
  input  logic [XLEN-1:0]          mul_wb_data_i,
  output logic                     commit_valid_o,
  output logic [TAG_W-1:0]         commit_tag_o,
  output logic [AREG_W-1:0]        commit_rd_o,
  output logic [XLEN-1:0]          commit_wdata_o
);

  entry_state_e        state_q [ROB_DEPTH];
  logic [AREG_W-1:0]   rd_q    [ROB_DEPTH];
  logic [XLEN-1:0]     data_q  [ROB_DEPTH];

  logic [TAG_W-1:0]    head_q;
  logic [TAG_W-1:0]    tail_q;
  logic [CNT_W-1:0]    count_q;

  logic                alloc_fire;
  logic                commit_fire;

  assign alloc_ready_o = (count_q != CNT_W'(ROB_DEPTH));
  assign tail_o        = tail_q;
  assign alloc_fire    = alloc_valid_i && alloc_ready_o && !flush_i;
  assign commit_fire   = !flush_i && (state_q[head_q] == ENTRY_DONE);

  // Operand lookup for dispatch
  always_comb begin
    for (int k = 0; k < 2; k++) begin
      query_done_o[k] = (state_q[query_tag_i[k]] == ENTRY_DONE);
      query_data_o[k] = data_q[query_tag_i[k]];
    end
  end

  // ====================
  // Entry state, pointers
  // ====================
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q        <= '{default: ENTRY_FREE};
      head_q         <= '0;
      tail_q         <= '0;
      count_q        <= '0;
      commit_valid_o <= 1'b0;
    end else if (flush_i) begin
      state_q        <= '{default: ENTRY_FREE};
      head_q         <= '0;
      tail_q         <= '0;
      count_q        <= '0;
      commit_valid_o <= 1'b0;
    end else begin
      if (alu_wb_valid_i) begin
        state_q[alu_wb_tag_i] <= ENTRY_DONE;
      end
      if (mul_wb_valid_i) begin
        state_q[mul_wb_tag_i] <= ENTRY_DONE;
      end
      if (alloc_fire) begin
        state_q[tail_q] <= ENTRY_PENDING;
        tail_q          <= tail_q + 1'b1;
      end
      // Retire at most one entry, oldest first
      if (commit_fire) begin
        state_q[head_q] <= ENTRY_FREE;
        head_q          <= head_q + 1'b1;
      end
      commit_valid_o <= commit_fire;
      count_q        <= count_q + CNT_W'(alloc_fire) - CNT_W'(commit_fire);
    end
  end

  // ====================
  // Payload
  // ====================
  always_ff @(posedge clk_i) begin
    if (alloc_fire) begin
      rd_q[tail_q] <= alloc_rd_i;
    end
    if (alu_wb_valid_i) begin
      data_q[alu_wb_tag_i] <= alu_wb_data_i;
    end
    if (mul_wb_valid_i) begin
      data_q[mul_wb_tag_i] <= mul_wb_data_i;
    end
    if (commit_fire) begin
      commit_tag_o   <= head_q;
      commit_rd_o    <= rd_q[head_q];
      commit_wdata_o <= data_q[head_q];
    end
  end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -Wno-fatal \
  --top-module tb_ooo_backend \
  -f ooo_backend.f \
  -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_tb +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "All tests passed" <<< "$output"; then
  exit 0
fi
exit 1

//--- tests/backend_properties.sv
`timescale 1ns/1ps
`default_nettype none

module backend_properties #(
  parameter int unsigned ROB_DEPTH = 8
) (
  input logic clk_i,
  input logic arst_n_i,
  input logic flush_i,
  input logic uop_valid_i,
  input logic uop_ready_o,
  input logic commit_valid_o
);

  int unsigned fail_count = 0;
  int unsigned outstanding_q;

  // Accepted but not yet committed
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      outstanding_q <= 0;
    end else if (flush_i) begin
      outstanding_q <= 0;
    end else begin
      outstanding_q <= outstanding_q + 32'(uop_valid_i && uop_ready_o) - 32'(commit_valid_o);
    end
  end

  // ====================
  // Protocol
  // ====================
  a_commit_known: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !$isunknown(commit_valid_o))
    else begin
      $error("commit_valid_o is unknown");
      fail_count++;
    end

  a_quiet_after_flush: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    flush_i |=> !commit_valid_o)
    else begin
      $error("commit in the cycle after a flush");
      fail_count++;
    end

  a_rob_bound: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    outstanding_q <= ROB_DEPTH)
    else begin
      $error("more uops outstanding than ROB entries");
      fail_count++;
    end

  a_stall_on_flush: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    flush_i |-> !uop_ready_o)
    else begin
      $error("uop_ready_o high during flush");
      fail_count++;
    end

endmodule

`default_nettype wire

//--- tests/tb_ooo_backend.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ooo_backend
  import backend_pkg::*;
();

  // Small ROB so that full stalls are reachable
  localparam int unsigned ROB_DEPTH = 4;
  localparam int N_RESET    = 7;
  localparam int N_CHAIN    = 40;
  localparam int N_MULORD   = 18;
  localparam int N_PRESSURE = 48;
  localparam int N_FLUSH    = 40;
  localparam int TOTAL_UOPS = N_RESET + N_CHAIN + N_MULORD + N_PRESSURE + N_FLUSH;
  localparam int WATCHDOG_CYCLES = TOTAL_UOPS * (ROB_DEPTH + MUL_STAGES + 4) + 20;

  logic                clk_i = 1'b0;
  logic                arst_n_i;
  logic                flush_i;
  logic                uop_valid_i;
  logic                uop_ready_o;
  alu_op_e             uop_op_i;
  logic [AREG_W-1:0]   uop_rd_i;
  logic [AREG_W-1:0]   uop_rs1_i;
  logic [AREG_W-1:0]   uop_rs2_i;
  logic [IMM_W-1:0]    uop_imm_i;
  logic                commit_valid_o;
  logic [AREG_W-1:0]   commit_rd_o;
  logic [XLEN-1:0]     commit_wdata_o;

  logic [XLEN-1:0]     spec_rf [2**AREG_W];
  logic [XLEN-1:0]     comm_rf [2**AREG_W];
  logic [AREG_W-1:0]   exp_rd_q [$];
  logic [XLEN-1:0]     exp_val_q [$];
  logic                head_valid = 1'b0;
  logic [AREG_W-1:0]   head_rd;
  logic [XLEN-1:0]     head_val;
  int                  errors = 0;
  int                  accept_count = 0;
  int                  commit_count = 0;
  int                  drop_count = 0;
  logic [31:0]         rng_state = 32'hb19d_6399;
  logic [AREG_W-1:0]   last_rd;

  always #50 clk_i = ~clk_i;

  ooo_backend #(
    .ROB_DEPTH(ROB_DEPTH)
  ) i_ooo_backend (
    .clk_i(clk_i), .arst_n_i(arst_n_i), .flush_i(flush_i),
    .uop_valid_i(uop_valid_i), .uop_ready_o(uop_ready_o), .uop_op_i(uop_op_i),
    .uop_rd_i(uop_rd_i), .uop_rs1_i(uop_rs1_i), .uop_rs2_i(uop_rs2_i),
    .uop_imm_i(uop_imm_i), .commit_valid_o(commit_valid_o),
    .commit_rd_o(commit_rd_o), .commit_wdata_o(commit_wdata_o)
  );

  bind ooo_backend backend_properties #(
    .ROB_DEPTH(ROB_DEPTH)
  ) i_backend_properties (
    .clk_i(clk_i), .arst_n_i(arst_n_i), .flush_i(flush_i),
    .uop_valid_i(uop_valid_i), .uop_ready_o(uop_ready_o),
    .commit_valid_o(commit_valid_o)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [XLEN-1:0] expected_result(input alu_op_e op,
      input logic [XLEN-1:0] a, input logic [XLEN-1:0] b, input logic [IMM_W-1:0] imm);
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      OP_ADDI: return a + {{(XLEN - IMM_W){imm[IMM_W-1]}}, imm};
      OP_MUL:  return a * b;
      default: return '0;
    endcase
  endfunction

  function automatic int total_errors();
    return errors + int'(i_ooo_backend.i_backend_properties.fail_count);
  endfunction

  // ====================
  // Reference model
  // ====================
  always @(posedge clk_i or negedge arst_n_i) begin
    logic [XLEN-1:0] result;
    if (!arst_n_i) begin
      spec_rf = '{default: '0};
      comm_rf = '{default: '0};
      exp_rd_q.delete();
      exp_val_q.delete();
    end else begin
      // Every commit pulse of the DUT counts, expected or not
      if (commit_valid_o) begin
        commit_count++;
      end
      // Oldest expectation leaves at the end of its commit cycle
      if (commit_valid_o && (exp_rd_q.size() > 0)) begin
        if (exp_rd_q[0] != '0) begin
          comm_rf[exp_rd_q[0]] = exp_val_q[0];
        end
        void'(exp_rd_q.pop_front());
        void'(exp_val_q.pop_front());
      end
      if (flush_i) begin
        drop_count += exp_rd_q.size();
        exp_rd_q.delete();
        exp_val_q.delete();
        spec_rf = comm_rf;
      end else if (uop_valid_i && uop_ready_o) begin
        result = expected_result(uop_op_i, spec_rf[uop_rs1_i], spec_rf[uop_rs2_i], uop_imm_i);
        if (uop_rd_i != '0) begin
          spec_rf[uop_rd_i] = result;
        end
        exp_rd_q.push_back(uop_rd_i);
        exp_val_q.push_back(result);
        accept_count++;
      end
    end
    head_valid = (exp_rd_q.size() > 0);
    if (head_valid) begin
      head_rd  = exp_rd_q[0];
      head_val = exp_val_q[0];
    end
  end

  // ====================
  // Commit checks
  // ====================
  a_commit_expected: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    commit_valid_o |-> head_valid)
    else begin
      $display("Commit at %0t ns with no accepted uop left to retire", $time);
      errors++;
    end

  a_commit_rd: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (commit_valid_o && head_valid) |-> (commit_rd_o == head_rd))
    else begin
      $display("error at %0t ns: commit_rd_o expected %0d, got %0d",
               $time, $sampled(head_rd), $sampled(commit_rd_o));
      errors++;
    end

  a_commit_data: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (commit_valid_o && head_valid) |-> (commit_wdata_o == head_val))
    else begin
      $display("error at %0t ns: commit_wdata_o expected %h, got %h",
               $time, $sampled(head_val), $sampled(commit_wdata_o));
      errors++;
    end

  a_ready_when_idle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (!head_valid && !flush_i) |-> uop_ready_o)
    else begin
      $display("uop_ready_o low at %0t ns with nothing outstanding", $time);
      errors++;
    end

  task automatic send_uop(input alu_op_e op, input logic [AREG_W-1:0] rd,
      input logic [AREG_W-1:0] rs1, input logic [AREG_W-1:0] rs2,
      input logic [IMM_W-1:0] imm);
    uop_valid_i <= 1'b1;
    uop_op_i    <= op;
    uop_rd_i    <= rd;
    uop_rs1_i   <= rs1;
    uop_rs2_i   <= rs2;
    uop_imm_i   <= imm;
    do begin
      @(posedge clk_i);
    end while (!uop_ready_o);
    last_rd = rd;
  endtask

  // Chains through the previous destination
  task automatic send_random(input int count, input bit with_mul);
    alu_op_e             op;
    logic [AREG_W-1:0]   rd;
    logic [AREG_W-1:0]   rs2;
    for (int i = 0; i < count; i++) begin
      rng_state = xorshift32(rng_state);
      op  = alu_op_e'(3'(rng_state[7:0] % (with_mul ? 7 : 6)));
      rd  = AREG_W'(rng_state[10:8]);
      rs2 = AREG_W'(rng_state[13:11]);
      send_uop(op, rd, last_rd, rs2, rng_state[31:16]);
    end
  endtask

  task automatic drain();
    uop_valid_i <= 1'b0;
    @(posedge clk_i);
    while (head_valid) begin
      @(posedge clk_i);
    end
    repeat (2) @(posedge clk_i);
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (total_errors() == errors_before) begin
      $display("Test %s: ok", name);
    end else begin
      $display("Test %s: %0d errors", name, total_errors() - errors_before);
    end
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles", WATCHDOG_CYCLES);
    $display("Some tests failed");
    $finish;
  end

  // ====================
  // Tests
  // ====================
  initial begin
    int base;
    arst_n_i    = 1'b0;
    flush_i     = 1'b0;
    uop_valid_i = 1'b0;
    uop_op_i    = OP_ADD;
    uop_rd_i    = '0;
    uop_rs1_i   = '0;
    uop_rs2_i   = '0;
    uop_imm_i   = '0;
    last_rd     = '0;
    repeat (5) @(posedge clk_i);
    arst_n_i <= 1'b1;

    base = total_errors();
    repeat (4) @(posedge clk_i);
    send_uop(OP_ADDI, 5'd1, 5'd0, 5'd0, 16'h1234);
    send_uop(OP_ADDI, 5'd2, 5'd0, 5'd0, 16'hfff0);
    send_uop(OP_ADDI, 5'd3, 5'd0, 5'd0, 16'h8000);
    send_uop(OP_ADDI, 5'd0, 5'd0, 5'd0, 16'h0055);
    send_uop(OP_ADD, 5'd4, 5'd0, 5'd1, '0);
    send_uop(OP_OR, 5'd5, 5'd0, 5'd0, '0);
    send_uop(OP_ADDI, 5'd6, 5'd0, 5'd0, 16'h0007);
    drain();
    report_test("1 after reset", base);

    base = total_errors();
    send_random(N_CHAIN, 1'b0);
    drain();
    report_test("2 dependent ALU chains", base);

    base = total_errors();
    for (int r = 0; r < 3; r++) begin
      rng_state = xorshift32(rng_state);
      send_uop(OP_ADDI, 5'd8, 5'd0, 5'd0, rng_state[15:0]);
      send_uop(OP_ADDI, 5'd9, 5'd1, 5'd0, rng_state[31:16]);
      send_uop(OP_MUL, 5'd10, 5'd8, 5'd9, '0);
      send_uop(OP_XOR, 5'd11, 5'd1, 5'd2, '0);
      send_uop(OP_ADD, 5'd12, 5'd3, 5'd4, '0);
      send_uop(OP_SUB, 5'd13, 5'd10, 5'd1, '0);
    end
    drain();
    report_test("3 multiply reordering", base);

    base = total_errors();
    for (int i = 0; i < 8; i++) begin
      send_uop(OP_MUL, AREG_W'(24 + i), 5'd8, 5'd9, '0);
    end
    send_random(N_PRESSURE - 8, 1'b1);
    drain();
    report_test("4 back-pressure", base);

    base = total_errors();
    for (int r = 0; r < 2; r++) begin
      send_random(8, 1'b1);
      uop_valid_i <= 1'b0;
      flush_i     <= 1'b1;
      @(posedge clk_i);
      flush_i <= 1'b0;
      send_random(12, 1'b1);
      drain();
    end
    report_test("5 flush", base);

    assert (accept_count == commit_count + drop_count) else begin
      $display("Accepted %0d uops, but %0d committed and %0d were flushed",
               accept_count, commit_count, drop_count);
      errors++;
    end

    $display("Summary: 5 tests, %0d accepted, %0d committed, %0d flushed, %0d errors",
             accept_count, commit_count, drop_count, total_errors());
    if (total_errors() == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
